// File: verification/vita_tx_stim.txt
# S addr data | W count then that many 36-bit input words | all hex except the W count
# E lane flags time s0 s1 s2 s3 | flags are has_secs sob eob eop from bit 3 down
S 0a 3
W 6 013000006 000000011 0a0000001 0a0000002 0a0000003 2a0000004
E 1 6 0 a0000001 0 0 0
E 1 2 0 a0000002 0 0 0
E 1 2 0 a0000003 0 0 0
E 1 3 0 a0000004 0 0 0
W 5 012500008 000000023 000001234 000000000 000005678
W 3 0b0000001 0b0000002 2b0000003
E 3 c 0000123400005678 b0000001 0 0 0
E 3 0 0 b0000002 0 0 0
E 3 1 0 b0000003 0 0 0
W 5 01300000a 000000002 0c0000001 0c0000002 0c0000003
W 5 0c0000004 0c0000005 0c0000006 0c0000007 2c0000008
E 2 6 0 c0000001 c0000002 c0000003 c0000004
E 2 3 0 c0000005 c0000006 c0000007 c0000008
W 7 01e000007 000000005 0deadbeef 00badf00d 0d0000001 0d0000002 2ffffffff
E 1 4 0 d0000001 0 0 0
E 1 1 0 d0000002 0 0 0
W 4 011000004 000000009 0e0000001 2e0000002
E 1 2 0 e0000001 0 0 0
E 1 3 0 e0000002 0 0 0
W 3 002000003 0f0000001 2f0000002
E 0 4 0 f0000001 0 0 0
E 0 1 0 f0000002 0 0 0
W 4 010400004 00000000c 0000000ab 211000001
E 0 9 000000ab00000000 11000001 0 0 0
W 7 010000007 000000006 0c1000001 0c1000002 0c1000003 0c1000004 2c1000005
E 2 0 0 c1000001 c1000002 c1000003 c1000004
E 2 1 0 c1000005 0 0 0

// File: tb.f
common/vita_tx_pkg.sv
src/setting_reg.sv
src/short_queue.sv
src/stream_dispatch.sv
vita_deframer/vita_tx_deframer.sv
src/sample_merge.sv
src/vita_tx_top.sv
verification/vita_tx_assert.sv
verification/tb_vita_tx.sv

// File: verification/tb_vita_tx.sv
module tb_vita_tx
   import vita_tx_pkg::*;
();

   localparam int CLK_PERIOD = 20;
   localparam int RESET_CYCLES = 8;
   localparam int CYCLES_PER_WORD = 40;
   localparam int EXP_DEPTH = 64;
   localparam logic [31:0] SEED = 32'd99416;

   logic clk;
   logic rst_n_i;
   logic clear_i;
   logic set_stb_i;
   logic [SR_ADDR_W-1:0] set_addr_i;
   logic [SR_DATA_W-1:0] set_data_i;
   word_t data_i;
   logic src_rdy_i;
   logic dst_rdy_o;
   sample_line_t sample_o;
   logic [LANE_W-1:0] lane_o;
   logic src_rdy_o;
   logic dst_rdy_i;

   word_t word_q [$];
   logic [SR_ADDR_W-1:0] set_addr_q [$];
   logic [SR_DATA_W-1:0] set_data_q [$];
   sample_line_t exp_mem [NUM_LANES][EXP_DEPTH];   // one fifo per lane
   int exp_wr [NUM_LANES];
   int exp_rd [NUM_LANES];
   int exp_total;
   int rx_count;
   int err_count;
   int missing;
   logic stim_ok;
   logic loaded;
   logic [31:0] drv_rnd;

   vita_tx_top vita_tx_top_inst (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .clear_i    (clear_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .data_i     (data_i),
      .src_rdy_i  (src_rdy_i),
      .dst_rdy_o  (dst_rdy_o),
      .sample_o   (sample_o),
      .lane_o     (lane_o),
      .src_rdy_o  (src_rdy_o),
      .dst_rdy_i  (dst_rdy_i)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic load_stim();
      int fd;
      int code;
      int n;
      int lane;
      logic [63:0] tag;
      logic [8*128-1:0] rest;
      logic [31:0] addr;
      logic [31:0] dat;
      word_t w;
      logic [3:0] flags;
      logic [63:0] tm;
      logic [31:0] s0, s1, s2, s3;
      fd = $fopen("verification/vita_tx_stim.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open verification/vita_tx_stim.txt");
         stim_ok = 1'b0;
         return;
      end
      code = $fscanf(fd, "%s", tag);
      while (code == 1)
      begin
         if (tag == "#")
            code = $fgets(rest, fd);
         else if (tag == "S")
         begin
            code = $fscanf(fd, "%h %h", addr, dat);
            set_addr_q.push_back(addr[SR_ADDR_W-1:0]);
            set_data_q.push_back(dat);
         end
         else if (tag == "W")
         begin
            code = $fscanf(fd, "%d", n);
            for (int i = 0; i < n; i++)
            begin
               code = $fscanf(fd, "%h", w);
               word_q.push_back(w);
            end
         end
         else if (tag == "E")
         begin
            code = $fscanf(fd, "%d %h %h %h %h %h %h", lane, flags, tm, s0, s1, s2, s3);
            if (lane < 0 || lane >= NUM_LANES || exp_wr[lane] == EXP_DEPTH)
            begin
               $display("expected line record out of range in stimulus file");
               stim_ok = 1'b0;
            end
            else
            begin
               // samples high, then has_secs sob eob eop, then send time
               exp_mem[lane][exp_wr[lane]] = {s3, s2, s1, s0, flags, tm};
               exp_wr[lane]++;
               exp_total++;
            end
         end
         else
         begin
            $display("unknown record %0s in stimulus file", tag);
            stim_ok = 1'b0;
         end
         code = $fscanf(fd, "%s", tag);
      end
      $fclose(fd);
   endtask

   task automatic check_beat(input int lane, input sample_line_t got);
      sample_line_t exp;
      if (exp_rd[lane] == exp_wr[lane])
      begin
         $display("ERROR %0t unexpected line on lane %0d, %h", $time, lane, got);
         err_count++;
      end
      else
      begin
         exp = exp_mem[lane][exp_rd[lane]];
         exp_rd[lane]++;
         if (got !== exp)
         begin
            $display("ERROR %0t lane %0d line mismatch", $time, lane);
            $display("   got      %h", got);
            $display("   expected %h", exp);
            err_count++;
         end
      end
   endtask

   task automatic write_settings();
      for (int i = 0; i < set_addr_q.size(); i++)
      begin
         @(negedge clk);
         set_stb_i = 1'b1;
         set_addr_i = set_addr_q[i];
         set_data_i = set_data_q[i];
      end
      @(negedge clk);
      set_stb_i = 1'b0;
   endtask

   task automatic send_word(input word_t w);
      logic done;
      done = 1'b0;
      while (!done)
      begin
         @(negedge clk);
         drv_rnd = xorshift(drv_rnd);
         if (drv_rnd[1:0] == 2'd0)
            src_rdy_i = 1'b0;   // idle gap
         else
         begin
            data_i = w;
            src_rdy_i = 1'b1;
            done = dst_rdy_o;   // taken at the next rising edge
         end
      end
   endtask

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      rst_n_i = 1'b0;
      clear_i = 1'b0;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      data_i = '0;
      src_rdy_i = 1'b0;
      dst_rdy_i = 1'b0;
      exp_total = 0;
      rx_count = 0;
      err_count = 0;
      missing = 0;
      drv_rnd = SEED;
      stim_ok = 1'b1;
      loaded = 1'b0;
      for (int l = 0; l < NUM_LANES; l++)
      begin
         exp_wr[l] = 0;
         exp_rd[l] = 0;
      end
      load_stim();
      loaded = 1'b1;
      if (!stim_ok)
      begin
         $display("stimulus file could not be read");
         $display("TEST RESULT: FAIL");
         $finish;
      end
      else
      begin
         repeat (RESET_CYCLES) @(posedge clk);
         @(negedge clk);
         rst_n_i = 1'b1;
         write_settings();
         for (int i = 0; i < word_q.size(); i++)
            send_word(word_q[i]);
         @(negedge clk);
         src_rdy_i = 1'b0;
         wait (rx_count >= exp_total);
         repeat (50) @(negedge clk);   // catch stray lines
         for (int l = 0; l < NUM_LANES; l++)
            missing += exp_wr[l] - exp_rd[l];
         $display("lines received %0d, expected %0d, errors %0d, missing %0d",
                  rx_count, exp_total, err_count, missing);
         if (err_count == 0 && missing == 0)
            $display("TEST RESULT: PASS");
         else
            $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // output side, random back-pressure
   initial
   begin
      logic [31:0] mon_rnd;
      mon_rnd = ~SEED;
      wait (rst_n_i);
      forever
      begin
         @(negedge clk);
         mon_rnd = xorshift(mon_rnd);
         dst_rdy_i = mon_rnd[0];
         if (src_rdy_o && dst_rdy_i)
         begin
            check_beat(int'(lane_o), sample_o);
            rx_count++;
         end
      end
   end

   initial
   begin
      wait (loaded);
      repeat (RESET_CYCLES + 20 + CYCLES_PER_WORD * word_q.size()) @(posedge clk);
      $display("watchdog expired with %0d of %0d lines received", rx_count, exp_total);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: verification/vita_tx_assert.sv
module vita_tx_assert
   import vita_tx_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     clear_i,
   input  logic                     out_valid_i,
   input  logic                     out_ready_i,
   input  logic [SAMPLE_LINE_W-1:0] sample_i,
   input  logic [LANE_W-1:0]        lane_i
);

   // one reset cycle empties every queue
   reset_quiet: assert property (@(posedge clk) !rst_n_i |=> !out_valid_i)
      else $error("src_rdy_o high right after a reset cycle");

   sample_hold: assert property (@(posedge clk) disable iff (!rst_n_i || clear_i)
      (out_valid_i && !out_ready_i) |=> $stable(sample_i))
      else $error("sample_o changed while stalled");

   lane_hold: assert property (@(posedge clk) disable iff (!rst_n_i || clear_i)
      (out_valid_i && !out_ready_i) |=> $stable(lane_i))
      else $error("lane_o changed while stalled");

endmodule

bind vita_tx_top vita_tx_assert vita_tx_assert_inst (
   .clk         (clk),
   .rst_n_i     (rst_n_i),
   .clear_i     (clear_i),
   .out_valid_i (src_rdy_o),
   .out_ready_i (dst_rdy_i),
   .sample_i    (sample_o),
   .lane_i      (lane_o)
);

// File: src/vita_tx_top.sv
module vita_tx_top
   import vita_tx_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     clear_i,
   input  logic                     set_stb_i,
   input  logic [SR_ADDR_W-1:0]     set_addr_i,
   input  logic [SR_DATA_W-1:0]     set_data_i,
   input  logic [LINE_W-1:0]        data_i,
   input  logic                     src_rdy_i,
   output logic                     dst_rdy_o,
   output logic [SAMPLE_LINE_W-1:0] sample_o,
   output logic [LANE_W-1:0]        lane_o,
   output logic                     src_rdy_o,
   input  logic                     dst_rdy_i
);

   word_t in_data;
   logic in_src_rdy;
   logic in_dst_rdy;
   word_t lane_data;
   logic [NUM_LANES-1:0] lane_src_rdy;
   logic [NUM_LANES-1:0] lane_dst_rdy;
   sample_line_t [NUM_LANES-1:0] lane_sample;
   logic [NUM_LANES-1:0] lane_sample_src_rdy;
   logic [NUM_LANES-1:0] lane_sample_dst_rdy;

   short_queue #(
      .payload_t (word_t)
   ) in_q_inst (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .clear_i   (clear_i),
      .data_i    (data_i),
      .src_rdy_i (src_rdy_i),
      .dst_rdy_o (dst_rdy_o),
      .data_o    (in_data),
      .src_rdy_o (in_src_rdy),
      .dst_rdy_i (in_dst_rdy)
   );

   stream_dispatch stream_dispatch_inst (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .clear_i        (clear_i),
      .data_i         (in_data),
      .src_rdy_i      (in_src_rdy),
      .dst_rdy_o      (in_dst_rdy),
      .data_o         (lane_data),
      .lane_src_rdy_o (lane_src_rdy),
      .lane_dst_rdy_i (lane_dst_rdy)
   );

   for (genvar g = 0; g < NUM_LANES; g++)
   begin : gen_lane
      vita_tx_deframer #(
         .LANE (g)
      ) deframer_inst (
         .clk              (clk),
         .rst_n_i          (rst_n_i),
         .clear_i          (clear_i),
         .set_stb_i        (set_stb_i),
         .set_addr_i       (set_addr_i),
         .set_data_i       (set_data_i),
         .data_i           (lane_data),
         .src_rdy_i        (lane_src_rdy[g]),
         .dst_rdy_o        (lane_dst_rdy[g]),
         .sample_o         (lane_sample[g]),
         .sample_src_rdy_o (lane_sample_src_rdy[g]),
         .sample_dst_rdy_i (lane_sample_dst_rdy[g])
      );
   end

   sample_merge sample_merge_inst (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .clear_i        (clear_i),
      .lane_sample_i  (lane_sample),
      .lane_src_rdy_i (lane_sample_src_rdy),
      .lane_dst_rdy_o (lane_sample_dst_rdy),
      .sample_o       (sample_o),
      .lane_o         (lane_o),
      .src_rdy_o      (src_rdy_o),
      .dst_rdy_i      (dst_rdy_i)
   );

endmodule

// File: src/sample_merge.sv
module sample_merge
   import vita_tx_pkg::*;
(
   input  logic                                   clk,
   input  logic                                   rst_n_i,
   input  logic                                   clear_i,
   input  logic [NUM_LANES-1:0][SAMPLE_LINE_W-1:0] lane_sample_i,
   input  logic [NUM_LANES-1:0]                   lane_src_rdy_i,
   output logic [NUM_LANES-1:0]                   lane_dst_rdy_o,
   output logic [SAMPLE_LINE_W-1:0]               sample_o,
   output logic [LANE_W-1:0]                      lane_o,
   output logic                                   src_rdy_o,
   input  logic                                   dst_rdy_i
);

   logic [LANE_W-1:0] last_q;
   logic [LANE_W-1:0] rr_grant;
   logic [LANE_W-1:0] grant;
   logic [LANE_W-1:0] idx;
   logic found;
   logic lock_q;
   logic [LANE_W-1:0] lock_lane_q;

   // first valid lane after the one served last
   always_comb
   begin
      rr_grant = last_q;
      found = 1'b0;
      idx = last_q;
      for (int k = 1; k <= NUM_LANES; k++)
      begin
         idx = last_q + LANE_W'(k);
         if (!found && lane_src_rdy_i[idx])
         begin
            rr_grant = idx;
            found = 1'b1;
         end
      end
   end

   // a stalled grant stays put, keeps the output stable
   assign grant = lock_q ? lock_lane_q : rr_grant;

   assign src_rdy_o = lane_src_rdy_i[grant];
   assign sample_o = lane_sample_i[grant];
   assign lane_o = grant;
   assign lane_dst_rdy_o = dst_rdy_i ? (NUM_LANES'(1) << grant) : '0;

   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         last_q <= LANE_W'(NUM_LANES - 1);   // lane 0 first
         lock_q <= 1'b0;
         lock_lane_q <= '0;
      end
      else
      begin
         lock_q <= src_rdy_o && !dst_rdy_i;
         lock_lane_q <= grant;
         if (src_rdy_o && dst_rdy_i)
            last_q <= grant;
      end
   end

endmodule

// File: vita_deframer/vita_tx_deframer.sv
module vita_tx_deframer
   import vita_tx_pkg::*;
#(
   parameter int LANE = 0
)
(
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 clear_i,
   input  logic                 set_stb_i,
   input  logic [SR_ADDR_W-1:0] set_addr_i,
   input  logic [SR_DATA_W-1:0] set_data_i,
   input  word_t                data_i,
   input  logic                 src_rdy_i,
   output logic                 dst_rdy_o,
   output sample_line_t         sample_o,
   output logic                 sample_src_rdy_o,
   input  logic                 sample_dst_rdy_i
);

   vita_state_t state_q;
   logic [NUMCHAN_W-1:0] numchan;
   logic cid_q, secs_q, tics_q, trl_q, sob_q, eob_q;
   logic [PKT_LEN_W-1:0] pkt_len_q;
   logic [PKT_LEN_W-1:0] word_cnt_q;
   logic [PKT_LEN_W-1:0] body_len;
   logic [NUMCHAN_W-1:0] phase_q;
   logic eop_q;
   logic [TIME_W-1:0] send_time_q;
   logic [SAMPLE_W-1:0] samp_q [MAX_CHAN];
   sample_line_t line_d;
   logic word_ok;
   logic store;
   logic store_fire;
   logic q_space;
   logic line_done;
   logic eop_now;
   logic hdr_secs, hdr_tics;

   setting_reg #(
      .ADDR (SR_NUMCHAN_BASE + LANE)
   ) numchan_reg_inst (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .value_o    (numchan)
   );

   function automatic vita_state_t after_cid(input logic secs, input logic tics);
      if (secs)
         return VITA_SECS;
      else if (tics)
         return VITA_TICS;
      else
         return VITA_PAYLOAD;
   endfunction

   assign hdr_secs = |data_i[HDR_TSI_HI:HDR_TSI_LO];
   assign hdr_tics = |data_i[HDR_TSF_HI:HDR_TSF_LO];

   assign dst_rdy_o = (state_q != VITA_STORE);
   assign word_ok = src_rdy_i && dst_rdy_o;
   assign store = (state_q == VITA_STORE);
   assign store_fire = store && q_space;
   assign line_done = (phase_q == numchan);
   assign body_len = pkt_len_q - PKT_LEN_W'(trl_q);   // trailer word is not payload
   assign eop_now = data_i[EOF_BIT] || ((word_cnt_q + 1'b1) == body_len);

   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         state_q <= VITA_HEADER;
         {cid_q, secs_q, tics_q, trl_q, sob_q, eob_q} <= '0;
         pkt_len_q <= '0;
         word_cnt_q <= '0;
         phase_q <= '0;
         eop_q <= 1'b0;
      end
      else if (store_fire)
      begin
         phase_q <= '0;
         eop_q <= 1'b0;
         sob_q <= 1'b0;    // sob and has_secs on the first line only
         secs_q <= 1'b0;
         if (!eop_q)
            state_q <= VITA_PAYLOAD;
         else if (trl_q)
            state_q <= VITA_TRAILER;
         else
            state_q <= VITA_HEADER;
      end
      else if (word_ok)
      begin
         word_cnt_q <= word_cnt_q + 1'b1;
         case (state_q)
            VITA_HEADER:
            begin
               cid_q <= data_i[HDR_CLASSID_BIT];
               secs_q <= hdr_secs;
               tics_q <= hdr_tics;
               trl_q <= data_i[HDR_TRAILER_BIT];
               sob_q <= data_i[HDR_SOB_BIT];
               eob_q <= data_i[HDR_EOB_BIT];
               pkt_len_q <= data_i[HDR_LEN_HI:HDR_LEN_LO];
               word_cnt_q <= PKT_LEN_W'(1);
               phase_q <= '0;
               if (data_i[HDR_SID_BIT])
                  state_q <= VITA_STREAMID;
               else if (data_i[HDR_CLASSID_BIT])
                  state_q <= VITA_CLASSID;
               else
                  state_q <= after_cid(hdr_secs, hdr_tics);
            end
            VITA_STREAMID:
               state_q <= cid_q ? VITA_CLASSID : after_cid(secs_q, tics_q);
            VITA_CLASSID:
               state_q <= VITA_CLASSID2;
            VITA_CLASSID2:
               state_q <= after_cid(secs_q, tics_q);
            VITA_SECS:
               state_q <= tics_q ? VITA_TICS : VITA_PAYLOAD;
            VITA_TICS:
               state_q <= VITA_TICS2;
            VITA_TICS2:
               state_q <= VITA_PAYLOAD;
            VITA_PAYLOAD:
            begin
               if (line_done || eop_now)
               begin
                  state_q <= VITA_STORE;
                  eop_q <= eop_now;   // short last line allowed
               end
               else
                  phase_q <= phase_q + 1'b1;
            end
            VITA_TRAILER:
               state_q <= VITA_HEADER;
            default:
               state_q <= VITA_HEADER;
         endcase
      end
   end

   // send time from the secs word and the low ticks word
   always_ff @(posedge clk)
   begin
      if (state_q == VITA_HEADER || store_fire)
         send_time_q <= '0;
      else if (word_ok && state_q == VITA_SECS)
         send_time_q[TIME_W-1 -: SAMPLE_W] <= data_i[SAMPLE_W-1:0];
      else if (word_ok && state_q == VITA_TICS2)
         send_time_q[SAMPLE_W-1:0] <= data_i[SAMPLE_W-1:0];
   end

   always_ff @(posedge clk)
   begin
      if (state_q == VITA_HEADER || store_fire)
      begin
         for (int i = 0; i < MAX_CHAN; i++)
            samp_q[i] <= '0;   // unused slots read as zero
      end
      else if (word_ok && state_q == VITA_PAYLOAD)
         samp_q[phase_q] <= data_i[SAMPLE_W-1:0];
   end

   always_comb
   begin
      line_d = '0;
      line_d[SL_TIME_LO +: TIME_W] = send_time_q;
      line_d[SL_EOP] = eop_q;
      line_d[SL_EOB] = eob_q;
      line_d[SL_SOB] = sob_q;
      line_d[SL_HAS_SECS] = secs_q;
      for (int i = 0; i < MAX_CHAN; i++)
         line_d[SL_SAMPLE_LO + SAMPLE_W * i +: SAMPLE_W] = samp_q[i];
   end

   short_queue #(
      .payload_t (sample_line_t)
   ) sample_q_inst (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .clear_i   (clear_i),
      .data_i    (line_d),
      .src_rdy_i (store),
      .dst_rdy_o (q_space),
      .data_o    (sample_o),
      .src_rdy_o (sample_src_rdy_o),
      .dst_rdy_i (sample_dst_rdy_i)
   );

endmodule

// File: src/stream_dispatch.sv
module stream_dispatch
   import vita_tx_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 clear_i,
   input  word_t                data_i,
   input  logic                 src_rdy_i,
   output logic                 dst_rdy_o,
   output word_t                data_o,
   output logic [NUM_LANES-1:0] lane_src_rdy_o,
   input  logic [NUM_LANES-1:0] lane_dst_rdy_i
);

   logic [LANE_W-1:0] lane_q;
   logic in_pkt_q;
   logic hold_q;      // header parked, waiting for the stream id word
   word_t hdr_q;
   logic has_sid;
   logic [LANE_W-1:0] sel_lane;
   logic fwd_valid;
   logic xfer_out;

   assign has_sid = data_i[HDR_SID_BIT];

   always_comb
   begin
      sel_lane = '0;
      fwd_valid = 1'b0;
      dst_rdy_o = 1'b0;
      if (hold_q)
      begin
         sel_lane = data_i[LANE_W-1:0];   // low bits of the stream id
         fwd_valid = src_rdy_i;
      end
      else if (in_pkt_q)
      begin
         sel_lane = lane_q;
         fwd_valid = src_rdy_i;
         dst_rdy_o = lane_dst_rdy_i[lane_q];
      end
      else if (has_sid)
         dst_rdy_o = 1'b1;
      else
      begin
         fwd_valid = src_rdy_i;   // no stream id, lane 0
         dst_rdy_o = lane_dst_rdy_i[0];
      end
   end

   assign data_o = hold_q ? hdr_q : data_i;
   assign lane_src_rdy_o = fwd_valid ? (NUM_LANES'(1) << sel_lane) : '0;
   assign xfer_out = fwd_valid && lane_dst_rdy_i[sel_lane];

   always_ff @(posedge clk)
   begin
      if (!hold_q && !in_pkt_q && src_rdy_i && has_sid)
         hdr_q <= data_i;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         lane_q <= '0;
         in_pkt_q <= 1'b0;
         hold_q <= 1'b0;
      end
      else if (hold_q)
      begin
         if (xfer_out)
         begin
            hold_q <= 1'b0;
            lane_q <= sel_lane;
            in_pkt_q <= !hdr_q[EOF_BIT];
         end
      end
      else if (in_pkt_q)
      begin
         if (xfer_out && data_i[EOF_BIT])
            in_pkt_q <= 1'b0;   // lane free again
      end
      else if (src_rdy_i)
      begin
         if (has_sid)
            hold_q <= 1'b1;
         else if (xfer_out)
         begin
            lane_q <= '0;
            in_pkt_q <= !data_i[EOF_BIT];
         end
      end
   end

endmodule

// File: src/short_queue.sv
module short_queue
   import vita_tx_pkg::*;
#(
   parameter type payload_t = word_t
)
(
   input  logic     clk,
   input  logic     rst_n_i,
   input  logic     clear_i,
   input  payload_t data_i,
   input  logic     src_rdy_i,
   output logic     dst_rdy_o,
   output payload_t data_o,
   output logic     src_rdy_o,
   input  logic     dst_rdy_i
);

   payload_t mem_q [QUEUE_DEPTH];
   logic [QPTR_W-1:0] wr_ptr_q;
   logic [QPTR_W-1:0] rd_ptr_q;
   logic [QCNT_W-1:0] count_q;
   logic wr_en;
   logic rd_en;

   assign dst_rdy_o = (count_q != QCNT_W'(QUEUE_DEPTH));
   assign src_rdy_o = (count_q != '0);
   assign data_o = mem_q[rd_ptr_q];

   assign wr_en = src_rdy_i && dst_rdy_o;
   assign rd_en = src_rdy_o && dst_rdy_i;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem_q[wr_ptr_q] <= data_i;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i || clear_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr_q <= wr_ptr_q + 1'b1;   // depth is a power of two
         if (rd_en)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         // simultaneous read and write leaves the count alone
         if (wr_en && !rd_en)
            count_q <= count_q + 1'b1;
         else if (rd_en && !wr_en)
            count_q <= count_q - 1'b1;
      end
   end

endmodule

// File: src/setting_reg.sv
module setting_reg
   import vita_tx_pkg::*;
#(
   parameter int ADDR = 0
)
(
   input  logic                 clk,
   input  logic                 rst_n_i,
   input  logic                 set_stb_i,
   input  logic [SR_ADDR_W-1:0] set_addr_i,
   input  logic [SR_DATA_W-1:0] set_data_i,
   output logic [NUMCHAN_W-1:0] value_o
);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == SR_ADDR_W'(ADDR));

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         value_o <= '0;
      else if (hit)
         value_o <= set_data_i[NUMCHAN_W-1:0];   // only the low bits matter
   end

endmodule

// File: common/vita_tx_pkg.sv
package vita_tx_pkg;

   localparam int NUM_LANES = 4;
   localparam int LANE_W = $clog2(NUM_LANES);
   localparam int MAX_CHAN = 4;
   localparam int NUMCHAN_W = $clog2(MAX_CHAN);

   localparam int LINE_W = 36;
   localparam int SAMPLE_W = 32;
   localparam int TIME_W = 64;
   localparam int SAMPLE_LINE_W = MAX_CHAN * SAMPLE_W + 4 + TIME_W;

   // sample line, lsb first: time, eop, eob, sob, has_secs, samples
   localparam int SL_TIME_LO = 0;
   localparam int SL_EOP = SL_TIME_LO + TIME_W;
   localparam int SL_EOB = SL_EOP + 1;
   localparam int SL_SOB = SL_EOP + 2;
   localparam int SL_HAS_SECS = SL_EOP + 3;
   localparam int SL_SAMPLE_LO = SL_EOP + 4;

   localparam int EOF_BIT = 33;          // end of frame, outside the vita word
   localparam int HDR_SID_BIT = 28;      // packet type 1, stream id present
   localparam int HDR_CLASSID_BIT = 27;
   localparam int HDR_TRAILER_BIT = 26;
   localparam int HDR_SOB_BIT = 25;
   localparam int HDR_EOB_BIT = 24;
   localparam int HDR_TSI_HI = 23;
   localparam int HDR_TSI_LO = 22;
   localparam int HDR_TSF_HI = 21;
   localparam int HDR_TSF_LO = 20;
   localparam int PKT_LEN_W = 16;
   localparam int HDR_LEN_LO = 0;
   localparam int HDR_LEN_HI = HDR_LEN_LO + PKT_LEN_W - 1;

   localparam int SR_ADDR_W = 8;
   localparam int SR_DATA_W = 32;
   localparam int SR_NUMCHAN_BASE = 8;   // lane i at base + i

   localparam int QUEUE_DEPTH = 4;
   localparam int QPTR_W = $clog2(QUEUE_DEPTH);
   localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

   typedef logic [LINE_W-1:0] word_t;
   typedef logic [SAMPLE_LINE_W-1:0] sample_line_t;

   typedef enum logic [3:0] {
      VITA_HEADER,
      VITA_STREAMID,
      VITA_CLASSID,
      VITA_CLASSID2,
      VITA_SECS,
      VITA_TICS,
      VITA_TICS2,
      VITA_PAYLOAD,
      VITA_STORE,
      VITA_TRAILER
   } vita_state_t;

endpackage
